// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := batch_interp_tb
FILELIST   := batch_interp.f
FLAGS      := --timing --assert --timescale 1ns/10ps
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -Wno-fatal
RUN_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== batch_interp.f ====
+incdir+hdl
hdl/interp_pkg.sv
hdl/interp_wb_regs.sv
hdl/pair_fifo.sv
hdl/interp_lane.sv
hdl/batch_interp.sv
testbench/batch_interp_checker.sv
testbench/batch_interp_tb.sv

// ==== hdl/batch_interp.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "interp_defs.svh"

module batch_interp (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [1:0]               wb_adr,
    input  logic [`FIXED_WIDTH-1:0]  wb_dat_w,
    output logic [`FIXED_WIDTH-1:0]  wb_dat_r,
    output logic                     wb_ack,
    output interp_pkg::batch_t       batch,
    output logic                     batch_valid
);
    import interp_pkg::*;

    logic                                  push;
    fixed_t                                push_x;
    fixed_t                                push_slope;
    logic                                  full;
    logic [$clog2(`FIFO_DEPTH + 1)-1:0]    level;
    logic                                  issue;
    fixed_t                                issue_x;
    fixed_t                                issue_slope;
    sample_t                               lane_sample [`BATCH_SIZE];
    logic [`LANE_LATENCY-1:0]              valid_sr;

    interp_wb_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .full       (full),
        .level      (level),
        .push       (push),
        .push_x     (push_x),
        .push_slope (push_slope)
    );

    pair_fifo fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_x      (push_x),
        .push_slope  (push_slope),
        .full        (full),
        .level       (level),
        .issue       (issue),
        .issue_x     (issue_x),
        .issue_slope (issue_slope)
    );

    for (genvar i = 0; i < `BATCH_SIZE; i++) begin : g_lane
        interp_lane #(.INDEX(i)) lane_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .issue_x     (issue_x),
            .issue_slope (issue_slope),
            .sample      (lane_sample[i])
        );
    end

    always_comb begin
        for (int i = 0; i < `BATCH_SIZE; i++) begin
            batch[i] = lane_sample[i];
        end
    end

    // Valid follows the pair through the lane stages.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`LANE_LATENCY-2:0], issue};
        end
    end

    assign batch_valid = valid_sr[`LANE_LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/interp_defs.svh ====
`ifndef INTERP_DEFS_SVH
`define INTERP_DEFS_SVH

// Datapath widths.
`define SAMPLE_WIDTH 16
`define FIXED_WIDTH  32
`define FRAC_BITS    16

// Batch shape and pair queue.
`define BATCH_SIZE   4
`define FIFO_DEPTH   4
`define LANE_LATENCY 3          // Multiply, add, round/saturate.

// Wishbone word addresses.
`define ADDR_X       0
`define ADDR_SLOPE   1          // Write pushes the (x, slope) pair.
`define ADDR_STATUS  2          // Queue level and full flag, read only.

`endif

// ==== hdl/interp_lane.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "interp_defs.svh"

module interp_lane #(
    parameter int INDEX = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  interp_pkg::fixed_t    issue_x,
    input  interp_pkg::fixed_t    issue_slope,
    output interp_pkg::sample_t   sample
);
    import interp_pkg::*;

    localparam int IDX_W   = $clog2(`BATCH_SIZE) + 1;       // Signed lane index.
    localparam int PROD_W  = `FIXED_WIDTH + IDX_W;
    localparam int SUM_W   = PROD_W + 1;
    localparam int ROUND_W = SUM_W + 1;

    localparam logic signed [IDX_W-1:0]   INDEX_S = IDX_W'(INDEX);
    localparam logic signed [ROUND_W-1:0] HALF    = ROUND_W'(1 << (`FRAC_BITS - 1));
    localparam logic signed [ROUND_W-1:0] SAT_MAX = ROUND_W'((1 << (`SAMPLE_WIDTH - 1)) - 1);
    localparam logic signed [ROUND_W-1:0] SAT_MIN = ~SAT_MAX;

    logic signed [PROD_W-1:0]  prod;
    fixed_t                    x_d1;
    logic signed [SUM_W-1:0]   sum;
    logic signed [ROUND_W-1:0] rounded;
    logic signed [ROUND_W-1:0] shifted;
    sample_t                   sat;

    // Floor of (value + 0.5), then clamp to the sample range.
    always_comb begin
        rounded = sum + HALF;
        shifted = rounded >>> `FRAC_BITS;
        if (shifted > SAT_MAX) begin
            sat = SAT_MAX[`SAMPLE_WIDTH-1:0];
        end else if (shifted < SAT_MIN) begin
            sat = SAT_MIN[`SAMPLE_WIDTH-1:0];
        end else begin
            sat = shifted[`SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod   <= '0;
            x_d1   <= '0;
            sum    <= '0;
            sample <= '0;
        end else begin
            prod   <= issue_slope * INDEX_S;    // Stage 1.
            x_d1   <= issue_x;
            sum    <= prod + x_d1;              // Stage 2.
            sample <= sat;                      // Stage 3.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/interp_pkg.sv ====
`default_nettype none

`include "interp_defs.svh"

package interp_pkg;

    // One output sample.
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Q16.16 start value or slope.
    typedef logic signed [`FIXED_WIDTH-1:0] fixed_t;

    // Element 0 holds sample 0 of the batch.
    typedef sample_t [`BATCH_SIZE-1:0] batch_t;

endpackage

`default_nettype wire

// ==== hdl/interp_wb_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "interp_defs.svh"

module interp_wb_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [1:0]                            wb_adr,
    input  logic [`FIXED_WIDTH-1:0]               wb_dat_w,
    output logic [`FIXED_WIDTH-1:0]               wb_dat_r,
    output logic                                  wb_ack,
    input  logic                                  full,
    input  logic [$clog2(`FIFO_DEPTH + 1)-1:0]    level,
    output logic                                  push,
    output interp_pkg::fixed_t                    push_x,
    output interp_pkg::fixed_t                    push_slope
);
    import interp_pkg::*;

    localparam int LEVEL_W = $clog2(`FIFO_DEPTH + 1);

    fixed_t x_reg;
    logic   req;
    logic   is_x_wr;
    logic   is_slope_wr;
    logic   accept;
    logic [`FIXED_WIDTH-1:0] rd_word;

    // New request only; the ack cycle itself is not a request.
    assign req         = wb_cyc && wb_stb && !wb_ack;
    assign is_x_wr     = wb_we && (wb_adr == 2'(`ADDR_X));
    assign is_slope_wr = wb_we && (wb_adr == 2'(`ADDR_SLOPE));
    assign accept      = req && !(is_slope_wr && full);   // Hold slope writes while full.

    // Pair enters the queue on the edge that raises the ack.
    assign push       = accept && is_slope_wr;
    assign push_x     = x_reg;
    assign push_slope = wb_dat_w;

    always_comb begin
        rd_word = '0;
        if (wb_adr == 2'(`ADDR_STATUS)) begin
            rd_word[`FIXED_WIDTH-1] = full;
            rd_word[LEVEL_W-1:0]    = level;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            x_reg    <= '0;
        end else begin
            wb_ack <= accept;
            if (accept && !wb_we) begin
                wb_dat_r <= rd_word;
            end
            if (accept && is_x_wr) begin
                x_reg <= wb_dat_w;          // Pending x for the next slope write.
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pair_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "interp_defs.svh"

module pair_fifo (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  push,
    input  interp_pkg::fixed_t                    push_x,
    input  interp_pkg::fixed_t                    push_slope,
    output logic                                  full,
    output logic [$clog2(`FIFO_DEPTH + 1)-1:0]    level,
    output logic                                  issue,
    output interp_pkg::fixed_t                    issue_x,
    output interp_pkg::fixed_t                    issue_slope
);
    import interp_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    fixed_t             x_mem     [`FIFO_DEPTH];
    fixed_t             slope_mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               pop;

    assign full  = (count == CNT_W'(`FIFO_DEPTH));
    assign level = count;
    assign wr_en = push && !full;
    assign pop   = (count != '0);           // No ready input, drain every clock.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            issue  <= 1'b0;
        end else begin
            issue <= pop;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            x_mem[wr_ptr]     <= push_x;
            slope_mem[wr_ptr] <= push_slope;
        end
        if (pop) begin
            issue_x     <= x_mem[rd_ptr];
            issue_slope <= slope_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== testbench/batch_interp_checker.sv ====
`default_nettype none
`timescale 1ns/10ps

module batch_interp_checker (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic batch_valid
);

    int fail_count = 0;                     // Read by the testbench at the end.

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack high outside a bus request");
        end

    ack_one_clock: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack held longer than one clock");
        end

    valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(batch_valid))
        else begin
            fail_count++;
            $error("batch_valid unknown after reset");
        end

    // Checked while reset is applied.
    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !batch_valid)
        else begin
            fail_count++;
            $error("batch_valid high during reset");
        end

endmodule

`default_nettype wire

// ==== testbench/batch_interp_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "interp_defs.svh"

module batch_interp_tb;
    import interp_pkg::*;

    localparam int TIMEOUT = 40;            // Clocks allowed for any one wait.

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    batch_t      batch;
    logic        batch_valid;

    batch_t exp_q [$];
    fixed_t model_x;
    int     model_level;
    logic   slope_push;
    logic   timed_out;
    int     err_batch;
    int     err_status;
    int     err_proto;
    int     err_timeout;

    batch_interp batch_interp_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .batch       (batch),
        .batch_valid (batch_valid)
    );

    bind batch_interp batch_interp_checker checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_ack      (wb_ack),
        .batch_valid (batch_valid)
    );

    always #50 clk = ~clk;

    // Floor of (x + slope*i + 0.5), clamped to the sample range.
    function automatic sample_t expected_sample(fixed_t x, fixed_t slope, int idx);
        longint v;
        longint smax;
        smax = (longint'(1) <<< (`SAMPLE_WIDTH - 1)) - 1;
        v = longint'(x) + longint'(slope) * idx;
        v = (v + (longint'(1) <<< (`FRAC_BITS - 1))) >>> `FRAC_BITS;
        if (v > smax) v = smax;
        if (v < -smax - 1) v = -smax - 1;
        return sample_t'(v);
    endfunction

    function automatic batch_t expected_batch(fixed_t x, fixed_t slope);
        batch_t b;
        for (int i = 0; i < `BATCH_SIZE; i++) begin
            b[i] = expected_sample(x, slope, i);
        end
        return b;
    endfunction

    function automatic fixed_t random_fixed(int span);
        int whole;
        whole = int'($urandom_range(2 * span)) - span;
        return fixed_t'(whole <<< `FRAC_BITS) + fixed_t'($urandom_range(16'hFFFF));
    endfunction

    // Queue occupancy: one push per accepted slope write, one pop per clock.
    assign slope_push = wb_cyc && wb_stb && wb_we && !wb_ack
                        && (wb_adr == 2'(`ADDR_SLOPE)) && (model_level != `FIFO_DEPTH);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_level <= 0;
        end else begin
            model_level <= model_level + int'(slope_push) - int'(model_level != 0);
        end
    end

    task automatic compare_batch(batch_t got, batch_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: batch got %h expected %h", $time, got, exp);
            err_batch++;
        end
    endtask

    task automatic compare_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            err_status++;
        end
    endtask

    // One Wishbone classic cycle; the snapshot is the status word at the accept edge.
    task automatic bus_cycle(logic we, logic [1:0] adr, logic [31:0] dat,
                             output logic [31:0] rdata, output logic [31:0] snap);
        logic got_ack;
        got_ack = 1'b0;
        rdata = '0;
        snap = '0;
        if (timed_out) return;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (wb_ack) begin
                got_ack = 1'b1;
                break;
            end
            snap = 32'(model_level);
            snap[31] = (model_level == `FIFO_DEPTH);
        end
        if (!got_ack) begin
            $display("ERROR at %0t: no wb_ack for access to address %0d", $time, adr);
            err_timeout++;
            timed_out = 1'b1;
        end else if (we && adr == 2'(`ADDR_X)) begin
            model_x = dat;
        end else if (we && adr == 2'(`ADDR_SLOPE)) begin
            exp_q.push_back(expected_batch(model_x, dat));
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(logic [1:0] adr, fixed_t dat);
        logic [31:0] unused_rd;
        logic [31:0] unused_snap;
        bus_cycle(1'b1, adr, dat, unused_rd, unused_snap);
    endtask

    task automatic check_status();
        logic [31:0] got;
        logic [31:0] exp;
        bus_cycle(1'b0, 2'(`ADDR_STATUS), '0, got, exp);
        if (!timed_out) compare_word("wb_dat_r", got, exp);
    endtask

    task automatic send_pair(fixed_t x, fixed_t slope);
        bus_write(2'(`ADDR_X), x);
        bus_write(2'(`ADDR_SLOPE), slope);
    endtask

    task automatic wait_drained();
        if (timed_out) return;
        for (int n = 0; n < TIMEOUT && exp_q.size() != 0; n++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("ERROR at %0t: %0d expected batches never arrived", $time, exp_q.size());
            err_timeout++;
            timed_out = 1'b1;
        end
    endtask

    // Each batch_valid consumes the oldest expected batch.
    always @(negedge clk) begin
        if (rst_n && batch_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: batch_valid with no batch expected", $time);
                err_batch++;
            end else begin
                compare_batch(batch, exp_q.pop_front());
            end
        end
    end

    initial begin
        int total;
        void'($urandom(98));
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        model_x = '0;
        timed_out = 1'b0;
        err_batch = 0;
        err_status = 0;
        err_proto = 0;
        err_timeout = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        repeat (6) begin                    // Idle bus after reset.
            @(negedge clk);
            if (wb_ack || batch_valid) begin
                $display("ERROR at %0t: activity on an idle bus after reset", $time);
                err_proto++;
            end
        end
        check_status();

        for (int n = 0; n < 12; n++) begin  // One pair at a time.
            send_pair(random_fixed('h7500), random_fixed(100));
            wait_drained();
        end

        bus_write(2'(`ADDR_X), random_fixed('h7500));
        for (int n = 0; n < 8; n++) begin   // Slope writes without waiting for output.
            bus_write(2'(`ADDR_SLOPE), random_fixed(100));
            check_status();
        end
        wait_drained();

        send_pair(32'h7FFF_FFFF, 32'h7FFF_FFFF);
        send_pair(32'h8000_0000, 32'h8000_0000);
        send_pair(32'h7FFF_8000, 32'h0000_0000);   // 32767.5 rounds up, then clamps.
        send_pair(32'h7FFF_7FFF, 32'h0000_0000);
        send_pair(32'hFFFF_8000, 32'h0000_0000);   // Half rounds toward plus.
        send_pair(32'h8000_0000, 32'hFFFF_FFFF);
        wait_drained();

        bus_write(2'(`ADDR_X), random_fixed('h7500));
        repeat (8) @(negedge clk);
        bus_write(2'(`ADDR_X), random_fixed('h7500));
        bus_write(2'(`ADDR_SLOPE), random_fixed(100));
        wait_drained();
        repeat (8) @(negedge clk);

        total = err_batch + err_status + err_proto + err_timeout
                + batch_interp_i.checker_i.fail_count;
        $display("Errors: batch %0d, status %0d, protocol %0d, timeout %0d, assertions %0d",
                 err_batch, err_status, err_proto, err_timeout,
                 batch_interp_i.checker_i.fail_count);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
